// File: files.f
common/adf4030_pkg.sv
rtl/bsync_generator.sv
rtl/trigger_select.sv
trigger/trigger_channel.sv
regmap/adf4030_regmap.sv
rtl/adf4030_sync_top.sv
verif/tb_clock_gen.sv
verif/adf4030_tb.sv

// File: verif/adf4030_tb.sv
`timescale 1ns/10ps
`default_nettype none

module adf4030_tb;

  import adf4030_pkg::*;

  localparam int TB_ID   = 32'h4030;
  localparam int CH_N    = 4;
  localparam int TIMEOUT = 20000;

  wire              device_clk;
  wire              rst;
  logic             bsync_in;
  logic             trigger;
  logic             wr_req;
  logic             rd_req;
  logic [7:0]       addr;
  logic [31:0]      wr_data;
  wire              sysref;
  wire [CH_N-1:0]   trig_channel;
  wire [31:0]       rd_data;
  wire              rd_ack;

  logic [31:0] lfsr_state = 32'd32018;
  int          cycle_count = 0;

  // Reference model state.
  logic [15:0] m_cnt;
  logic [4:0]  m_dly;
  logic        m_sysref;
  logic        m_event;
  logic [2:0]  m_bstate;
  logic        m_captured;
  logic        m_err;
  logic [2:0]  m_bs;
  logic [2:0]  m_tg;
  logic        m_trig;
  logic [5:0]  m_ctrl;
  logic [15:0] m_ratio;
  logic [4:0]  m_delay;
  logic [31:0] m_scratch;
  logic        m_manual;
  logic        m_errclr;
  logic [CH_N-1:0] m_ch_en;
  logic [15:0] m_phase [CH_N];
  logic [2:0]  m_state [CH_N];
  logic [15:0] m_wait  [CH_N];
  logic        m_rd_ack;
  logic [31:0] m_rd_data;

  tb_clock_gen clock_gen (
    .device_clk (device_clk),
    .rst        (rst));

  adf4030_sync_top #(
    .ID            (TB_ID),
    .CHANNEL_COUNT (CH_N)
  ) UUT (
    .device_clk   (device_clk),
    .rst          (rst),
    .bsync_in     (bsync_in),
    .trigger      (trigger),
    .wr_req       (wr_req),
    .rd_req       (rd_req),
    .addr         (addr),
    .wr_data      (wr_data),
    .sysref       (sysref),
    .trig_channel (trig_channel),
    .rd_data      (rd_data),
    .rd_ack       (rd_ack));

  task automatic stop_run(input string reason);
    if (reason != "") $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail %s expected %h got %h", name, expected, actual);
      stop_run("");
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] model_read(input logic [7:0] a);
    logic [31:0] v;
    v = '0;
    case (a)
      REG_ID:        v = TB_ID;
      REG_SCRATCH:   v = m_scratch;
      REG_CONTROL:   v[5:0] = m_ctrl;
      REG_BSYNC_CFG: v = {11'b0, m_delay, m_ratio};
      REG_STATUS:    v = {25'b0, m_bstate, 1'b0, m_captured, m_err, m_bstate == BS_LOCKED};
      REG_CH_EN:     v[CH_N-1:0] = m_ch_en;
      default: begin
        for (int i = 0; i < CH_N; i++) begin
          if (a == 8'h10 + i) v[15:0] = m_phase[i];
          if (a == 8'h20 + i) v[2:0] = m_state[i];
        end
      end
    endcase
    return v;
  endfunction

  always @(posedge device_clk) begin : model
    logic wrap_m;
    logic zero_m;
    logic edge_m;
    logic tedge_m;
    wrap_m  = (m_cnt >= m_ratio - 16'd1);
    edge_m  = m_bs[1] & ~m_bs[2];
    zero_m  = m_ctrl[0] ? edge_m : wrap_m;
    tedge_m = m_tg[1] & ~m_tg[2];
    if (rst) begin
      m_cnt <= '1;  // First cycle after reset opens a period.
      m_dly <= '0;
      m_sysref <= 1'b0;
      m_event <= 1'b0;
      m_bstate <= BS_IDLE;
      m_captured <= 1'b0;
      m_err <= 1'b0;
      m_bs <= '0;
      m_tg <= '0;
      m_trig <= 1'b0;
      m_ctrl <= '0;
      m_ratio <= 16'd16;
      m_delay <= '0;
      m_manual <= 1'b0;
      m_errclr <= 1'b0;
      m_ch_en <= '0;
      m_rd_ack <= 1'b0;
      for (int i = 0; i < CH_N; i++) begin
        m_phase[i] <= '0;
        m_state[i] <= TR_IDLE;
        m_wait[i] <= '0;
      end
    end else begin
      m_bs <= {m_bs[1:0], bsync_in};
      m_tg <= {m_tg[1:0], trigger};
      m_cnt <= (zero_m || wrap_m) ? 16'd0 : m_cnt + 16'd1;
      m_sysref <= wrap_m & ~m_ctrl[0] & ~m_ctrl[1];
      m_event <= (zero_m && m_delay == 5'd0) || (m_dly == 5'd1);
      if (zero_m) m_dly <= m_delay;
      else if (m_dly != 5'd0) m_dly <= m_dly - 5'd1;
      if (m_bstate == BS_IDLE && zero_m) m_bstate <= BS_WAIT;
      if (m_bstate == BS_WAIT && m_event) m_bstate <= BS_LOCKED;
      if (m_ctrl[0] && edge_m) m_captured <= 1'b1;
      if (m_errclr) m_err <= 1'b0;
      else if (m_ctrl[5] && m_ctrl[0] && m_captured && edge_m && !wrap_m) m_err <= 1'b1;
      m_trig <= m_ctrl[3] ? 1'b0 : (m_ctrl[2] ? tedge_m : m_manual);
      for (int i = 0; i < CH_N; i++) begin
        case (m_state[i])
          TR_IDLE:  if (m_trig && m_ch_en[i] && m_bstate == BS_LOCKED) m_state[i] <= TR_ARMED;
          TR_ARMED: begin
            if (m_event) begin
              m_wait[i]  <= m_phase[i];
              m_state[i] <= (m_phase[i] == 16'd0) ? TR_FIRE : TR_PHASE;
            end
          end
          TR_PHASE: begin
            m_wait[i] <= m_wait[i] - 16'd1;
            if (m_wait[i] == 16'd1) m_state[i] <= TR_FIRE;
          end
          default:  m_state[i] <= TR_IDLE;
        endcase
      end
      m_manual <= wr_req && addr == REG_ACTION && wr_data[0];
      m_errclr <= wr_req && addr == REG_ACTION && wr_data[1];
      if (wr_req) begin
        if (addr == REG_SCRATCH) m_scratch <= wr_data;
        if (addr == REG_CONTROL) m_ctrl <= wr_data[5:0];
        if (addr == REG_BSYNC_CFG) begin
          m_ratio <= wr_data[15:0];
          m_delay <= wr_data[20:16];
        end
        if (addr == REG_CH_EN) m_ch_en <= wr_data[CH_N-1:0];
        for (int i = 0; i < CH_N; i++) begin
          if (addr == 8'h10 + i) m_phase[i] <= wr_data[15:0];
        end
      end
      m_rd_ack <= rd_req;
      if (rd_req) m_rd_data <= model_read(addr);
    end
  end

  // Outputs are compared mid-cycle against the model.
  always @(negedge device_clk) begin : compare_outputs
    logic [CH_N-1:0] exp_tc;
    if (!rst) begin
      for (int i = 0; i < CH_N; i++) begin
        exp_tc[i] = m_ctrl[3] ? m_ctrl[4] : (m_state[i] == TR_FIRE);
      end
      check_value("sysref", m_sysref, sysref);
      check_value("trig_channel", exp_tc, trig_channel);
      check_value("rd_ack", m_rd_ack, rd_ack);
      if (rd_ack) check_value("rd_data", m_rd_data, rd_data);
    end
  end

  always @(posedge device_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT) stop_run("Timeout, the tests did not finish in time");
  end

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge device_clk);
      #2;
    end
  endtask

  task automatic write_reg(input logic [7:0] a, input logic [31:0] d);
    addr    = a;
    wr_data = d;
    wr_req  = 1'b1;
    wait_cycles(1);
    wr_req  = 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] a, output logic [31:0] d);
    int n;
    n      = 0;
    addr   = a;
    rd_req = 1'b1;
    wait_cycles(1);
    rd_req = 1'b0;
    while (!rd_ack) begin
      if (n >= 8) begin
        stop_run("Read request was never acknowledged");
      end else begin
        wait_cycles(1);
        n++;
      end
    end
    d = rd_data;
  endtask

  task automatic wait_channels_idle(input int limit);
    int n;
    logic busy;
    n    = 0;
    busy = 1'b1;
    while (busy) begin
      busy = 1'b0;
      for (int i = 0; i < CH_N; i++) busy |= (m_state[i] != TR_IDLE);
      if (busy && n >= limit) begin
        stop_run("Channels did not return to idle");
      end else if (busy) begin
        wait_cycles(1);
        n++;
      end
    end
  endtask

  task automatic pulse_bsync(input int spacing);
    bsync_in = 1'b1;
    wait_cycles(2);
    bsync_in = 1'b0;
    wait_cycles(spacing - 2);
  endtask

  initial begin : stimulus
    logic [31:0] d;
    logic [31:0] v;
    int          ratio;
    int          delay;
    int          hits;
    bsync_in = 1'b0;
    trigger  = 1'b0;
    wr_req   = 1'b0;
    rd_req   = 1'b0;
    addr     = '0;
    wr_data  = '0;
    wait (rst == 1'b0);
    wait_cycles(2);

    // Register access.
    read_reg(REG_ID, d);
    check_value("REG_ID", TB_ID, d);
    v = take_bits(32);
    write_reg(REG_SCRATCH, v);
    read_reg(REG_SCRATCH, d);
    check_value("REG_SCRATCH", v, d);
    v = take_bits(6);
    write_reg(REG_CONTROL, v);
    read_reg(REG_CONTROL, d);
    check_value("REG_CONTROL", v & 32'h3f, d);
    v = {11'b0, 5'(take_bits(5)), 16'(16'd32 + take_bits(6))};
    write_reg(REG_BSYNC_CFG, v);
    read_reg(REG_BSYNC_CFG, d);
    check_value("REG_BSYNC_CFG", v & 32'h1fffff, d);
    v = take_bits(CH_N);
    write_reg(REG_CH_EN, v);
    read_reg(REG_CH_EN, d);
    check_value("REG_CH_EN", v, d);
    for (int i = 0; i < CH_N; i++) begin
      v = take_bits(16);
      write_reg(REG_CH_PHASE + i, v);
      read_reg(REG_CH_PHASE + i, d);
      check_value("REG_CH_PHASE", v, d);
    end

    // Internal sync period.
    write_reg(REG_CONTROL, 32'h0);
    ratio = 4 + take_bits(5);
    delay = take_bits(5);
    if (delay >= ratio) delay = ratio - 1;
    write_reg(REG_BSYNC_CFG, (delay << 16) | ratio);
    wait_cycles(ratio + 2);
    hits = 0;
    repeat (3 * ratio) begin
      wait_cycles(1);
      if (sysref) hits++;
    end
    check_value("sysref_count", 3, hits);
    write_reg(REG_CONTROL, 32'h2);
    wait_cycles(2);
    hits = 0;
    repeat (2 * ratio) begin
      wait_cycles(1);
      if (sysref) hits++;
    end
    check_value("sysref_disabled_count", 0, hits);
    write_reg(REG_CONTROL, 32'h0);
    wait_cycles(ratio + delay + 2);
    read_reg(REG_STATUS, d);
    check_value("REG_STATUS", 32'h21, d);

    // Manual triggers with aligned firing.
    write_reg(REG_BSYNC_CFG, (take_bits(3) << 16) | (8 + take_bits(4)));
    for (int i = 0; i < CH_N; i++) write_reg(REG_CH_PHASE + i, take_bits(4));
    repeat (8) begin
      write_reg(REG_CH_EN, take_bits(CH_N));
      write_reg(REG_CH_PHASE + take_bits(2), take_bits(4));
      wait_cycles(take_bits(5));
      write_reg(REG_ACTION, 32'h1);
      if (take_bits(1)) begin
        wait_cycles(take_bits(3));
        write_reg(REG_ACTION, 32'h1);  // Lands on busy channels.
      end
    end
    wait_channels_idle(200);

    // External trigger input.
    write_reg(REG_CH_EN, 32'hf);
    write_reg(REG_CONTROL, 32'h4);
    repeat (6) begin
      wait_cycles(take_bits(5));
      trigger = 1'b1;
      wait_cycles(1 + take_bits(3));
      trigger = 1'b0;
    end
    wait_channels_idle(200);

    // External sync and misalignment.
    ratio = 8 + take_bits(4);
    write_reg(REG_BSYNC_CFG, ratio);
    write_reg(REG_CONTROL, 32'h21);
    repeat (3) pulse_bsync(ratio);
    pulse_bsync(ratio - 1);  // The status read fills the last cycle.
    read_reg(REG_STATUS, d);
    check_value("REG_STATUS", 32'h25, d);
    pulse_bsync(ratio + 3);
    pulse_bsync(ratio);
    read_reg(REG_STATUS, d);
    check_value("REG_STATUS", 32'h27, d);
    write_reg(REG_ACTION, 32'h2);
    wait_cycles(2);
    read_reg(REG_STATUS, d);
    check_value("REG_STATUS", 32'h25, d);

    // Debug override.
    write_reg(REG_CONTROL, 32'h0);
    repeat (6) begin
      v = take_bits(2);
      write_reg(REG_CONTROL, {27'b0, v[1], 1'b1, v[0], 2'b0});
      write_reg(REG_ACTION, 32'h1);
      trigger = 1'b1;
      wait_cycles(4 + take_bits(3));
      trigger = 1'b0;
      wait_cycles(4);
    end
    write_reg(REG_CONTROL, 32'h0);
    wait_cycles(4);
    for (int i = 0; i < CH_N; i++) begin
      read_reg(REG_CH_STATE + i, d);
      check_value("REG_CH_STATE", TR_IDLE, d);
    end

    wait_cycles(4);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic device_clk,
  output logic rst
);

  initial begin
    device_clk = 1'b0;
    forever #10 device_clk = ~device_clk;  // 20 ns period.
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge device_clk);
    #2 rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: rtl/adf4030_sync_top.sv
`timescale 1ns/10ps
`default_nettype none

module adf4030_sync_top #(
  parameter int ID            = 0,
  parameter int CHANNEL_COUNT = 4
) (
  input  wire                            device_clk,
  input  wire                            rst,
  input  wire                            bsync_in,
  input  wire                            trigger,
  input  wire                            wr_req,
  input  wire                            rd_req,
  input  wire [adf4030_pkg::ADDR_W-1:0]  addr,
  input  wire [adf4030_pkg::DATA_W-1:0]  wr_data,
  output logic                           sysref,
  output wire [CHANNEL_COUNT-1:0]        trig_channel,
  output logic [adf4030_pkg::DATA_W-1:0] rd_data,
  output logic                           rd_ack
);

  import adf4030_pkg::*;

  logic               direction;
  logic               disable_internal_bsync;
  logic               enable_misalign_check;
  logic               error_clear;
  logic [RATIO_W-1:0] bsync_ratio;
  logic [DELAY_W-1:0] bsync_delay;
  logic               bsync_event;
  logic               bsync_ready;
  logic               bsync_alignment_error;
  logic               bsync_captured;
  bsync_state_t       bsync_state;
  logic               select_trig;
  logic               manual_trig;
  logic               enable_debug_trig;
  logic               debug_trig;
  logic               trig;

  logic [CHANNEL_COUNT-1:0] ch_en;
  logic [PHASE_W-1:0]       ch_phase   [CHANNEL_COUNT];
  trig_state_t              trig_state [CHANNEL_COUNT];
  wire  [CHANNEL_COUNT-1:0] trig_out;

  bsync_generator i_bsync_gen (
    .device_clk             (device_clk),
    .rst                    (rst),
    .direction              (direction),
    .bsync_in               (bsync_in),
    .disable_internal_bsync (disable_internal_bsync),
    .enable_misalign_check  (enable_misalign_check),
    .error_clear            (error_clear),
    .bsync_ratio            (bsync_ratio),
    .bsync_delay            (bsync_delay),
    .sysref                 (sysref),
    .bsync_event            (bsync_event),
    .bsync_ready            (bsync_ready),
    .bsync_alignment_error  (bsync_alignment_error),
    .bsync_captured         (bsync_captured),
    .bsync_state            (bsync_state));

  trigger_select i_trig_sel (
    .device_clk        (device_clk),
    .rst               (rst),
    .trigger           (trigger),
    .manual_trig       (manual_trig),
    .select_trig       (select_trig),
    .enable_debug_trig (enable_debug_trig),
    .trig              (trig));

  for (genvar i = 0; i < CHANNEL_COUNT; i++) begin : gen_channel
    trigger_channel i_channel (
      .device_clk  (device_clk),
      .rst         (rst),
      .trig        (trig),
      .ch_en       (ch_en[i]),
      .ch_phase    (ch_phase[i]),
      .bsync_event (bsync_event),
      .bsync_ready (bsync_ready),
      .trig_state  (trig_state[i]),
      .trig_out    (trig_out[i]));

    assign trig_channel[i] = enable_debug_trig ? debug_trig : trig_out[i];  // Debug override.
  end

  adf4030_regmap #(
    .ID            (ID),
    .CHANNEL_COUNT (CHANNEL_COUNT)
  ) i_regmap (
    .device_clk             (device_clk),
    .rst                    (rst),
    .wr_req                 (wr_req),
    .rd_req                 (rd_req),
    .addr                   (addr),
    .wr_data                (wr_data),
    .rd_data                (rd_data),
    .rd_ack                 (rd_ack),
    .bsync_ready            (bsync_ready),
    .bsync_alignment_error  (bsync_alignment_error),
    .bsync_captured         (bsync_captured),
    .bsync_state            (bsync_state),
    .trig_state             (trig_state),
    .direction              (direction),
    .disable_internal_bsync (disable_internal_bsync),
    .select_trig            (select_trig),
    .enable_debug_trig      (enable_debug_trig),
    .debug_trig             (debug_trig),
    .enable_misalign_check  (enable_misalign_check),
    .manual_trig            (manual_trig),
    .error_clear            (error_clear),
    .bsync_ratio            (bsync_ratio),
    .bsync_delay            (bsync_delay),
    .ch_en                  (ch_en),
    .ch_phase               (ch_phase));

endmodule

`default_nettype wire

// File: regmap/adf4030_regmap.sv
`timescale 1ns/10ps
`default_nettype none

module adf4030_regmap #(
  parameter int ID            = 0,
  parameter int CHANNEL_COUNT = 4
) (
  input  wire                             device_clk,
  input  wire                             rst,
  input  wire                             wr_req,
  input  wire                             rd_req,
  input  wire  [adf4030_pkg::ADDR_W-1:0]  addr,
  input  wire  [adf4030_pkg::DATA_W-1:0]  wr_data,
  output logic [adf4030_pkg::DATA_W-1:0]  rd_data,
  output logic                            rd_ack,
  input  wire                             bsync_ready,
  input  wire                             bsync_alignment_error,
  input  wire                             bsync_captured,
  input  wire  adf4030_pkg::bsync_state_t bsync_state,
  input  wire  adf4030_pkg::trig_state_t  trig_state [CHANNEL_COUNT],
  output logic                            direction,
  output logic                            disable_internal_bsync,
  output logic                            select_trig,
  output logic                            enable_debug_trig,
  output logic                            debug_trig,
  output logic                            enable_misalign_check,
  output logic                            manual_trig,
  output logic                            error_clear,
  output logic [adf4030_pkg::RATIO_W-1:0] bsync_ratio,
  output logic [adf4030_pkg::DELAY_W-1:0] bsync_delay,
  output logic [CHANNEL_COUNT-1:0]        ch_en,
  output logic [adf4030_pkg::PHASE_W-1:0] ch_phase [CHANNEL_COUNT]
);

  import adf4030_pkg::*;

  logic [CTRL_W-1:0] control;
  logic [DATA_W-1:0] scratch;
  logic [DATA_W-1:0] rd_mux;

  assign direction              = control[CTRL_DIRECTION];
  assign disable_internal_bsync = control[CTRL_DISABLE_BSYNC];
  assign select_trig            = control[CTRL_SELECT_TRIG];
  assign enable_debug_trig      = control[CTRL_ENABLE_DEBUG];
  assign debug_trig             = control[CTRL_DEBUG_TRIG];
  assign enable_misalign_check  = control[CTRL_MISALIGN];

  always_ff @(posedge device_clk) begin
    if (rst) begin
      control     <= '0;
      manual_trig <= 1'b0;
      error_clear <= 1'b0;
      bsync_ratio <= RATIO_RESET;
      bsync_delay <= '0;
      ch_en       <= '0;
      rd_ack      <= 1'b0;
      for (int i = 0; i < CHANNEL_COUNT; i++) begin
        ch_phase[i] <= '0;
      end
    end else begin
      // Action bits live for a single cycle.
      manual_trig <= wr_req && (addr == REG_ACTION) && wr_data[ACT_MANUAL_TRIG];
      error_clear <= wr_req && (addr == REG_ACTION) && wr_data[ACT_ERROR_CLEAR];
      rd_ack      <= rd_req;
      if (wr_req) begin
        case (addr)
          REG_CONTROL: begin
            control <= wr_data[CTRL_W-1:0];
          end
          REG_BSYNC_CFG: begin
            bsync_ratio <= wr_data[RATIO_W-1:0];
            bsync_delay <= wr_data[RATIO_W +: DELAY_W];
          end
          REG_CH_EN: begin
            ch_en <= wr_data[CHANNEL_COUNT-1:0];
          end
          default: begin
          end
        endcase
        for (int i = 0; i < CHANNEL_COUNT; i++) begin
          if (addr == REG_CH_PHASE + ADDR_W'(i)) begin
            ch_phase[i] <= wr_data[PHASE_W-1:0];
          end
        end
      end
    end
  end

  always_ff @(posedge device_clk) begin
    if (wr_req && addr == REG_SCRATCH) begin
      scratch <= wr_data;
    end
  end

  always_comb begin
    rd_mux = '0;
    case (addr)
      REG_ID: begin
        rd_mux = DATA_W'(ID);
      end
      REG_SCRATCH: begin
        rd_mux = scratch;
      end
      REG_CONTROL: begin
        rd_mux[CTRL_W-1:0] = control;
      end
      REG_BSYNC_CFG: begin
        rd_mux[RATIO_W-1:0]        = bsync_ratio;
        rd_mux[RATIO_W +: DELAY_W] = bsync_delay;
      end
      REG_STATUS: begin
        rd_mux[0]   = bsync_ready;
        rd_mux[1]   = bsync_alignment_error;
        rd_mux[2]   = bsync_captured;
        rd_mux[6:4] = bsync_state;
      end
      REG_CH_EN: begin
        rd_mux[CHANNEL_COUNT-1:0] = ch_en;
      end
      default: begin
        // Per-channel windows, anything else reads zero.
        for (int i = 0; i < CHANNEL_COUNT; i++) begin
          if (addr == REG_CH_PHASE + ADDR_W'(i)) begin
            rd_mux[PHASE_W-1:0] = ch_phase[i];
          end
          if (addr == REG_CH_STATE + ADDR_W'(i)) begin
            rd_mux[2:0] = trig_state[i];
          end
        end
      end
    endcase
  end

  always_ff @(posedge device_clk) begin
    if (rd_req) begin
      rd_data <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// File: trigger/trigger_channel.sv
`timescale 1ns/10ps
`default_nettype none

module trigger_channel (
  input  wire                            device_clk,
  input  wire                            rst,
  input  wire                            trig,
  input  wire                            ch_en,
  input  wire [adf4030_pkg::PHASE_W-1:0] ch_phase,
  input  wire                            bsync_event,
  input  wire                            bsync_ready,
  output adf4030_pkg::trig_state_t       trig_state,
  output logic                           trig_out
);

  import adf4030_pkg::*;

  logic [PHASE_W-1:0] phase_cnt;

  always_ff @(posedge device_clk) begin
    if (rst) begin
      trig_state <= TR_IDLE;
    end else begin
      case (trig_state)
        TR_IDLE: begin
          if (trig && ch_en && bsync_ready) begin
            trig_state <= TR_ARMED;
          end
        end
        TR_ARMED: begin
          if (bsync_event) begin
            // Zero phase fires right after the event.
            trig_state <= (ch_phase == '0) ? TR_FIRE : TR_PHASE;
          end
        end
        TR_PHASE: begin
          if (phase_cnt == PHASE_W'(1)) begin
            trig_state <= TR_FIRE;
          end
        end
        TR_FIRE: begin
          trig_state <= TR_IDLE;
        end
        default: begin
          trig_state <= TR_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge device_clk) begin
    if (trig_state == TR_ARMED && bsync_event) begin
      phase_cnt <= ch_phase;
    end else if (trig_state == TR_PHASE) begin
      phase_cnt <= phase_cnt - 1'b1;
    end
  end

  assign trig_out = (trig_state == TR_FIRE);  // One cycle wide.

endmodule

`default_nettype wire

// File: rtl/trigger_select.sv
`timescale 1ns/10ps
`default_nettype none

module trigger_select (
  input  wire  device_clk,
  input  wire  rst,
  input  wire  trigger,
  input  wire  manual_trig,
  input  wire  select_trig,
  input  wire  enable_debug_trig,
  output logic trig
);

  logic trig_meta;
  logic trig_sync;
  logic trig_sync_d;
  logic trig_edge;

  always_ff @(posedge device_clk) begin
    if (rst) begin
      trig_meta   <= 1'b0;
      trig_sync   <= 1'b0;
      trig_sync_d <= 1'b0;
    end else begin
      trig_meta   <= trigger;  // Asynchronous pin.
      trig_sync   <= trig_meta;
      trig_sync_d <= trig_sync;
    end
  end

  assign trig_edge = trig_sync & ~trig_sync_d;

  always_ff @(posedge device_clk) begin
    if (rst) begin
      trig <= 1'b0;
    end else if (enable_debug_trig) begin
      trig <= 1'b0;  // Debug mode blocks all triggers.
    end else begin
      trig <= select_trig ? trig_edge : manual_trig;
    end
  end

endmodule

`default_nettype wire

// File: rtl/bsync_generator.sv
`timescale 1ns/10ps
`default_nettype none

module bsync_generator (
  input  wire                            device_clk,
  input  wire                            rst,
  input  wire                            direction,
  input  wire                            bsync_in,
  input  wire                            disable_internal_bsync,
  input  wire                            enable_misalign_check,
  input  wire                            error_clear,
  input  wire [adf4030_pkg::RATIO_W-1:0] bsync_ratio,
  input  wire [adf4030_pkg::DELAY_W-1:0] bsync_delay,
  output logic                           sysref,
  output logic                           bsync_event,
  output logic                           bsync_ready,
  output logic                           bsync_alignment_error,
  output logic                           bsync_captured,
  output adf4030_pkg::bsync_state_t      bsync_state
);

  import adf4030_pkg::*;

  logic               bsync_meta;
  logic               bsync_sync;
  logic               bsync_sync_d;
  logic               ext_edge;
  logic               wrap;
  logic               zero_next;
  logic [RATIO_W-1:0] cnt;
  logic [DELAY_W-1:0] dly_cnt;

  always_ff @(posedge device_clk) begin
    if (rst) begin
      bsync_meta   <= 1'b0;
      bsync_sync   <= 1'b0;
      bsync_sync_d <= 1'b0;
    end else begin
      bsync_meta   <= bsync_in;
      bsync_sync   <= bsync_meta;
      bsync_sync_d <= bsync_sync;
    end
  end

  // The cycle after ext_edge is the count-0 cycle in external mode.
  assign ext_edge  = bsync_sync & ~bsync_sync_d;
  assign wrap      = (cnt >= bsync_ratio - 1'b1);
  assign zero_next = direction ? ext_edge : wrap;

  always_ff @(posedge device_clk) begin
    if (rst) begin
      cnt    <= '1;  // Wraps to 0 on the first cycle.
      sysref <= 1'b0;
    end else begin
      cnt    <= (zero_next || wrap) ? '0 : cnt + 1'b1;
      sysref <= wrap & ~direction & ~disable_internal_bsync;
    end
  end

  always_ff @(posedge device_clk) begin
    if (rst) begin
      dly_cnt     <= '0;
      bsync_event <= 1'b0;
    end else begin
      bsync_event <= (zero_next && (bsync_delay == '0)) || (dly_cnt == DELAY_W'(1));
      if (zero_next) begin
        dly_cnt <= bsync_delay;
      end else if (dly_cnt != '0) begin
        dly_cnt <= dly_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge device_clk) begin
    if (rst) begin
      bsync_state <= BS_IDLE;
    end else begin
      case (bsync_state)
        BS_IDLE:   if (zero_next) bsync_state <= BS_WAIT;
        BS_WAIT:   if (bsync_event) bsync_state <= BS_LOCKED;
        BS_LOCKED: bsync_state <= BS_LOCKED;  // Lock is held until reset.
        default:   bsync_state <= BS_IDLE;
      endcase
    end
  end

  assign bsync_ready = (bsync_state == BS_LOCKED);

  always_ff @(posedge device_clk) begin
    if (rst) begin
      bsync_captured        <= 1'b0;
      bsync_alignment_error <= 1'b0;
    end else begin
      if (direction && ext_edge) begin
        bsync_captured <= 1'b1;
      end
      if (error_clear) begin
        bsync_alignment_error <= 1'b0;
      end else if (enable_misalign_check && direction && bsync_captured &&
                   ext_edge && !wrap) begin
        bsync_alignment_error <= 1'b1;  // Edge off the expected period.
      end
    end
  end

endmodule

`default_nettype wire

// File: common/adf4030_pkg.sv
`default_nettype none

package adf4030_pkg;

  localparam int RATIO_W = 16;  // Sync period.
  localparam int DELAY_W = 5;
  localparam int PHASE_W = 16;
  localparam int ADDR_W  = 8;
  localparam int DATA_W  = 32;

  localparam logic [ADDR_W-1:0] REG_ID        = 8'h00;
  localparam logic [ADDR_W-1:0] REG_SCRATCH   = 8'h01;
  localparam logic [ADDR_W-1:0] REG_CONTROL   = 8'h02;
  localparam logic [ADDR_W-1:0] REG_ACTION    = 8'h03;  // Write-only pulses.
  localparam logic [ADDR_W-1:0] REG_BSYNC_CFG = 8'h04;
  localparam logic [ADDR_W-1:0] REG_STATUS    = 8'h05;
  localparam logic [ADDR_W-1:0] REG_CH_EN     = 8'h08;
  localparam logic [ADDR_W-1:0] REG_CH_PHASE  = 8'h10;  // One word per channel.
  localparam logic [ADDR_W-1:0] REG_CH_STATE  = 8'h20;

  // Control register bits.
  localparam int CTRL_DIRECTION     = 0;
  localparam int CTRL_DISABLE_BSYNC = 1;
  localparam int CTRL_SELECT_TRIG   = 2;
  localparam int CTRL_ENABLE_DEBUG  = 3;
  localparam int CTRL_DEBUG_TRIG    = 4;
  localparam int CTRL_MISALIGN      = 5;
  localparam int CTRL_W             = 6;

  localparam int ACT_MANUAL_TRIG = 0;
  localparam int ACT_ERROR_CLEAR = 1;

  localparam logic [RATIO_W-1:0] RATIO_RESET = 16'd16;

  typedef enum logic [2:0] {
    BS_IDLE   = 3'd0,
    BS_WAIT   = 3'd1,
    BS_LOCKED = 3'd2
  } bsync_state_t;

  typedef enum logic [2:0] {
    TR_IDLE  = 3'd0,
    TR_ARMED = 3'd1,
    TR_PHASE = 3'd2,
    TR_FIRE  = 3'd3
  } trig_state_t;

endpackage

`default_nettype wire
